//--- Bender.yml
package:
  name: nameTable

sources:
  - logic/nameTablePkg.sv
  - logic/nameTableRam.sv
  - logic/cpuWriteSlave.sv
  - logic/flashLoader.sv
  - logic/writeArbiter.sv
  - logic/tileFetch.sv
  - logic/nameTableTop.sv
  - target: test
    files:
      - sim/nameTable_checker.sv
      - sim/tb_nameTable.sv

//--- logic/cpuWriteSlave.sv
/* axi4-lite write slave */

`timescale 1ns/1ps
`default_nettype none

module cpuWriteSlave (
    input  wire                    clk_flashToNametable,
    input  wire                    rst,
    input  wire                    awvalid,
    output logic                   awready,
    input  nameTablePkg::busAddrT  awaddr,
    input  wire                    wvalid,
    output logic                   wready,
    input  nameTablePkg::wordT     wdata,
    input  nameTablePkg::byteEnT   wstrb,
    output logic                   bvalid,
    input  wire                    bready,
    output logic [1:0]             bresp,
    output logic                   cpuReq,
    input  wire                    cpuGrant,
    output nameTablePkg::wordAddrT cpuAddr,
    output nameTablePkg::wordT     cpuData,
    output nameTablePkg::byteEnT   cpuByteEn
);

    nameTablePkg::slaveStateT state;
    logic                     awHave;
    logic                     wHave;
    logic                     awFire;
    logic                     wFire;
    nameTablePkg::busAddrT    addrReg;
    nameTablePkg::wordT       dataReg;
    nameTablePkg::byteEnT     strbReg;

    // each channel open in idle until its own beat is taken
    assign awready = (state == nameTablePkg::slvIdle) && !awHave;
    assign wready  = (state == nameTablePkg::slvIdle) && !wHave;
    assign awFire  = awvalid && awready;
    assign wFire   = wvalid && wready;

    // a 10-bit byte address always lands inside the 256 words
    assign cpuReq    = (state == nameTablePkg::slvWrite);
    assign cpuAddr   = addrReg[9:2];
    assign cpuData   = dataReg;
    assign cpuByteEn = strbReg;

    assign bvalid = (state == nameTablePkg::slvRespond);
    assign bresp  = nameTablePkg::respOkay;

    always_ff @(posedge clk_flashToNametable) begin
        if (rst) begin
            state  <= nameTablePkg::slvIdle;
            awHave <= 1'b0;
            wHave  <= 1'b0;
        end else begin
            case (state)
                nameTablePkg::slvIdle: begin
                    if (awFire) begin
                        awHave <= 1'b1;
                    end
                    if (wFire) begin
                        wHave <= 1'b1;
                    end
                    // both channels in hand, address and data in either order
                    if ((awHave || awFire) && (wHave || wFire)) begin
                        state <= nameTablePkg::slvWrite;
                    end
                end
                nameTablePkg::slvWrite: begin
                    // processor has priority so the grant comes right away
                    if (cpuGrant) begin
                        state  <= nameTablePkg::slvRespond;
                        awHave <= 1'b0;
                        wHave  <= 1'b0;
                    end
                end
                nameTablePkg::slvRespond: begin
                    if (bready) begin
                        state <= nameTablePkg::slvIdle;
                    end
                end
                default: begin
                    state <= nameTablePkg::slvIdle;
                end
            endcase
        end
    end

    // captured beats
    always_ff @(posedge clk_flashToNametable) begin
        if (awFire) begin
            addrReg <= awaddr;
        end
        if (wFire) begin
            dataReg <= wdata;
            strbReg <= wstrb;
        end
    end

endmodule

`default_nettype wire

//--- logic/flashLoader.sv
/* flash byte stream loader */

`timescale 1ns/1ps
`default_nettype none

module flashLoader (
    input  wire                    clk_flashToNametable,
    input  wire                    rst,
    input  wire                    loadStart,
    input  wire                    flashValid,
    output logic                   flashReady,
    input  nameTablePkg::tileIdxT  flashByte,
    output logic                   loadReq,
    input  wire                    loadGrant,
    output nameTablePkg::wordAddrT loadAddr,
    output nameTablePkg::wordT     loadData,
    output logic                   loadDone
);

    nameTablePkg::loadStateT state;
    nameTablePkg::wordAddrT  wordCnt;
    logic [1:0]              byteCnt;
    nameTablePkg::wordT      shiftReg;
    logic                    byteFire;

    // stream stalls while a finished word waits for its grant
    assign flashReady = (state == nameTablePkg::ldCollect);
    assign byteFire   = flashValid && flashReady;

    assign loadReq  = (state == nameTablePkg::ldRequest);
    assign loadAddr = wordCnt;
    assign loadData = shiftReg;
    assign loadDone = (state == nameTablePkg::ldDone);

    always_ff @(posedge clk_flashToNametable) begin
        if (rst) begin
            state   <= nameTablePkg::ldIdle;
            wordCnt <= '0;
            byteCnt <= '0;
        end else begin
            case (state)
                nameTablePkg::ldIdle: begin
                    if (loadStart) begin
                        state   <= nameTablePkg::ldCollect;
                        wordCnt <= '0;
                        byteCnt <= '0;
                    end
                end
                nameTablePkg::ldCollect: begin
                    if (byteFire) begin
                        byteCnt <= byteCnt + 2'd1;
                        // fourth byte completes the word
                        if (byteCnt == 2'd3) begin
                            state <= nameTablePkg::ldRequest;
                        end
                    end
                end
                nameTablePkg::ldRequest: begin
                    if (loadGrant) begin
                        if (wordCnt == nameTablePkg::wordAddrT'(nameTablePkg::tableWords - 1)) begin
                            state <= nameTablePkg::ldDone;
                        end else begin
                            state   <= nameTablePkg::ldCollect;
                            wordCnt <= wordCnt + 8'd1;
                        end
                    end
                end
                // one cycle of done, then back to idle
                default: begin
                    state <= nameTablePkg::ldIdle;
                end
            endcase
        end
    end

    // first byte of a word ends up in lane 0
    always_ff @(posedge clk_flashToNametable) begin
        if (byteFire) begin
            shiftReg <= {flashByte, shiftReg[31:8]};
        end
    end

endmodule

`default_nettype wire

//--- logic/nameTablePkg.sv
/* name table shared definitions */

`default_nettype none

package nameTablePkg;

    // widths that carry a meaning
    typedef logic [31:0] wordT;
    typedef logic [7:0]  wordAddrT;
    typedef logic [3:0]  byteEnT;
    typedef logic [4:0]  tileCoordT;
    typedef logic [7:0]  tileIdxT;
    typedef logic [1:0]  paletteT;
    typedef logic [9:0]  busAddrT;

    // ram geometry and address map
    localparam int ramDepth   = 256;
    // 32 x 30 tiles, four per word
    localparam int nameWords  = 240;
    // attribute bytes sit right after the name words
    localparam int attrBase   = nameWords;
    localparam int tableWords = 256;

    // axi write response codes
    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // loader FSM
    typedef enum logic [1:0] {ldIdle, ldCollect, ldRequest, ldDone} loadStateT;

    // axi write slave FSM
    typedef enum logic [1:0] {slvIdle, slvWrite, slvRespond} slaveStateT;

endpackage

`default_nettype wire

//--- logic/nameTableRam.sv
/* name table block ram */

`timescale 1ns/1ps
`default_nettype none

module nameTableRam (
    input  wire                    clk_flashToNametable,
    input  nameTablePkg::byteEnT   writeEn,
    input  nameTablePkg::wordAddrT writeAddr,
    input  nameTablePkg::wordT     writeData,
    input  nameTablePkg::wordAddrT nameAddr,
    output nameTablePkg::wordT     nameData,
    input  nameTablePkg::wordAddrT attrAddr,
    output nameTablePkg::wordT     attrData
);

    // tile indices in words 0..239, attribute bytes above
    nameTablePkg::wordT mem [0:nameTablePkg::ramDepth-1];

    // byte lane i of the enable writes byte i of the word
    always_ff @(posedge clk_flashToNametable) begin
        if (writeEn[0]) begin
            mem[writeAddr][7:0] <= writeData[7:0];
        end
        if (writeEn[1]) begin
            mem[writeAddr][15:8] <= writeData[15:8];
        end
        if (writeEn[2]) begin
            mem[writeAddr][23:16] <= writeData[23:16];
        end
        if (writeEn[3]) begin
            mem[writeAddr][31:24] <= writeData[31:24];
        end
    end

    // name read port for the fetch pipeline
    always_ff @(posedge clk_flashToNametable) begin
        nameData <= mem[nameAddr];
    end

    // attribute read port, same latency
    always_ff @(posedge clk_flashToNametable) begin
        attrData <= mem[attrAddr];
    end

endmodule

`default_nettype wire

//--- logic/nameTableTop.sv
/* name table store top */

`timescale 1ns/1ps
`default_nettype none

module nameTableTop (
    input  wire                     clk_flashToNametable,
    input  wire                     rst,
    // axi4-lite write channels
    input  wire                     awvalid,
    output logic                    awready,
    input  nameTablePkg::busAddrT   awaddr,
    input  wire                     wvalid,
    output logic                    wready,
    input  nameTablePkg::wordT      wdata,
    input  nameTablePkg::byteEnT    wstrb,
    output logic                    bvalid,
    input  wire                     bready,
    output logic [1:0]              bresp,
    // flash stream
    input  wire                     flashValid,
    output logic                    flashReady,
    input  nameTablePkg::tileIdxT   flashByte,
    input  wire                     loadStart,
    output logic                    loadDone,
    // renderer fetch port
    input  wire                     fetchValid,
    input  nameTablePkg::tileCoordT tileX,
    input  nameTablePkg::tileCoordT tileY,
    output logic                    tileValid,
    output nameTablePkg::tileIdxT   tileIndex,
    output nameTablePkg::paletteT   paletteSel
);

    logic                   cpuReq;
    logic                   cpuGrant;
    nameTablePkg::wordAddrT cpuAddr;
    nameTablePkg::wordT     cpuData;
    nameTablePkg::byteEnT   cpuByteEn;
    logic                   loadReq;
    logic                   loadGrant;
    nameTablePkg::wordAddrT loadAddr;
    nameTablePkg::wordT     loadData;
    nameTablePkg::byteEnT   writeEn;
    nameTablePkg::wordAddrT writeAddr;
    nameTablePkg::wordT     writeData;
    nameTablePkg::wordAddrT nameAddr;
    nameTablePkg::wordT     nameData;
    nameTablePkg::wordAddrT attrAddr;
    nameTablePkg::wordT     attrData;

    cpuWriteSlave u_cpuWriteSlave (
        .clk_flashToNametable(clk_flashToNametable),
        .rst(rst),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .wdata(wdata),
        .wstrb(wstrb),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .cpuReq(cpuReq),
        .cpuGrant(cpuGrant),
        .cpuAddr(cpuAddr),
        .cpuData(cpuData),
        .cpuByteEn(cpuByteEn)
    );

    flashLoader u_flashLoader (
        .clk_flashToNametable(clk_flashToNametable),
        .rst(rst),
        .loadStart(loadStart),
        .flashValid(flashValid),
        .flashReady(flashReady),
        .flashByte(flashByte),
        .loadReq(loadReq),
        .loadGrant(loadGrant),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .loadDone(loadDone)
    );

    writeArbiter u_writeArbiter (
        .clk_flashToNametable(clk_flashToNametable),
        .rst(rst),
        .cpuReq(cpuReq),
        .cpuAddr(cpuAddr),
        .cpuData(cpuData),
        .cpuByteEn(cpuByteEn),
        .cpuGrant(cpuGrant),
        .loadReq(loadReq),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .loadGrant(loadGrant),
        .writeEn(writeEn),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    nameTableRam u_nameTableRam (
        .clk_flashToNametable(clk_flashToNametable),
        .writeEn(writeEn),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .nameAddr(nameAddr),
        .nameData(nameData),
        .attrAddr(attrAddr),
        .attrData(attrData)
    );

    tileFetch u_tileFetch (
        .clk_flashToNametable(clk_flashToNametable),
        .rst(rst),
        .fetchValid(fetchValid),
        .tileX(tileX),
        .tileY(tileY),
        .nameAddr(nameAddr),
        .attrAddr(attrAddr),
        .nameData(nameData),
        .attrData(attrData),
        .tileValid(tileValid),
        .tileIndex(tileIndex),
        .paletteSel(paletteSel)
    );

endmodule

`default_nettype wire

//--- logic/tileFetch.sv
/* tile fetch pipeline */

`timescale 1ns/1ps
`default_nettype none

module tileFetch (
    input  wire                     clk_flashToNametable,
    input  wire                     rst,
    input  wire                     fetchValid,
    input  nameTablePkg::tileCoordT tileX,
    input  nameTablePkg::tileCoordT tileY,
    output nameTablePkg::wordAddrT  nameAddr,
    output nameTablePkg::wordAddrT  attrAddr,
    input  nameTablePkg::wordT      nameData,
    input  nameTablePkg::wordT      attrData,
    output logic                    tileValid,
    output nameTablePkg::tileIdxT   tileIndex,
    output nameTablePkg::paletteT   paletteSel
);

    logic [9:0] tileNum;
    logic [5:0] attrByte;
    // stage 1 side info, travels with the ram read
    logic       validS1;
    logic [1:0] nameLaneS1;
    logic [1:0] attrLaneS1;
    logic [2:0] palShiftS1;
    logic [7:0] attrSel;

    // row times 32 plus column
    assign tileNum  = {tileY, tileX};
    // one attribute byte per 4x4 tile block, 8 per block row
    assign attrByte = {tileY[4:2], tileX[4:2]};

    assign nameAddr = tileNum[9:2];
    assign attrAddr = nameTablePkg::wordAddrT'(nameTablePkg::attrBase) + {4'd0, attrByte[5:2]};

    always_ff @(posedge clk_flashToNametable) begin
        if (rst) begin
            validS1   <= 1'b0;
            tileValid <= 1'b0;
        end else begin
            validS1   <= fetchValid;
            tileValid <= validS1;
        end
    end

    // stage 1 lane and shift
    always_ff @(posedge clk_flashToNametable) begin
        nameLaneS1 <= tileNum[1:0];
        attrLaneS1 <= attrByte[1:0];
        // quadrant inside the block, 4 per row half plus 2 per column half
        palShiftS1 <= {tileY[1], tileX[1], 1'b0};
    end

    // attribute byte out of the read word
    assign attrSel = attrData[8*attrLaneS1 +: 8];

    // stage 2 byte and field select
    always_ff @(posedge clk_flashToNametable) begin
        tileIndex  <= nameData[8*nameLaneS1 +: 8];
        paletteSel <= nameTablePkg::paletteT'(attrSel >> palShiftS1);
    end

endmodule

`default_nettype wire

//--- logic/writeArbiter.sv
/* ram write port arbiter */

`timescale 1ns/1ps
`default_nettype none

module writeArbiter (
    input  wire                    clk_flashToNametable,
    input  wire                    rst,
    input  wire                    cpuReq,
    input  nameTablePkg::wordAddrT cpuAddr,
    input  nameTablePkg::wordT     cpuData,
    input  nameTablePkg::byteEnT   cpuByteEn,
    output logic                   cpuGrant,
    input  wire                    loadReq,
    input  nameTablePkg::wordAddrT loadAddr,
    input  nameTablePkg::wordT     loadData,
    output logic                   loadGrant,
    output nameTablePkg::byteEnT   writeEn,
    output nameTablePkg::wordAddrT writeAddr,
    output nameTablePkg::wordT     writeData
);

    // loader stall cycles, saturating, for debug after reset
    logic [15:0] stallCount;
    logic        loadStall;

    // processor first, loader only on a free cycle
    assign cpuGrant  = cpuReq;
    assign loadGrant = loadReq && !cpuReq;
    assign loadStall = loadReq && !loadGrant;

    // single write port of the ram
    always_comb begin
        if (cpuGrant) begin
            writeEn   = cpuByteEn;
            writeAddr = cpuAddr;
            writeData = cpuData;
        end else if (loadGrant) begin
            // loader always writes whole words
            writeEn   = 4'hf;
            writeAddr = loadAddr;
            writeData = loadData;
        end else begin
            writeEn   = '0;
            writeAddr = loadAddr;
            writeData = loadData;
        end
    end

    always_ff @(posedge clk_flashToNametable) begin
        if (rst) begin
            stallCount <= '0;
        end else if (loadStall && (stallCount != 16'hffff)) begin
            stallCount <= stallCount + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- sim/nameTable_checker.sv
/* name table protocol checks */

`timescale 1ns/1ps
`default_nettype none

module nameTable_checker (
    input wire                    clk_flashToNametable,
    input wire                    rst,
    input wire                    cpuReq,
    input wire                    cpuGrant,
    input wire                    loadReq,
    input wire                    loadGrant,
    input nameTablePkg::wordAddrT loadAddr,
    input wire                    bvalid,
    input wire                    bready,
    input wire                    fetchValid,
    input wire                    tileValid
);

    // failures seen by the testbench at the end of the run
    int failCount;

    initial begin
        failCount = 0;
    end

    // single write port, one grant at a time
    grantExclusive: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        !(cpuGrant && loadGrant))
        else begin
            failCount++;
            $error("processor and loader granted in the same cycle");
        end

    // processor write lasts one cycle, response follows
    cpuWriteThenResp: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        cpuReq |=> bvalid && !cpuReq)
        else begin
            failCount++;
            $error("processor request not followed by a response on the next cycle");
        end

    // waiting loader word holds its address
    loadReqHeld: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        loadReq && !loadGrant |=> loadReq && $stable(loadAddr))
        else begin
            failCount++;
            $error("loader request dropped or changed address before grant");
        end

    // response held until taken
    respHeld: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            failCount++;
            $error("bvalid fell before bready");
        end

    // fixed two cycle fetch latency, both directions
    fetchLatency: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        fetchValid |-> ##2 tileValid)
        else begin
            failCount++;
            $error("tileValid missing two cycles after fetchValid");
        end

    noSpuriousTile: assert property (@(posedge clk_flashToNametable) disable iff (rst)
        tileValid |-> $past(fetchValid, 2))
        else begin
            failCount++;
            $error("tileValid without a fetch two cycles earlier");
        end

endmodule

// all watched nets are visible in the top level scope
bind nameTableTop nameTable_checker u_checker (
    .clk_flashToNametable(clk_flashToNametable),
    .rst(rst),
    .cpuReq(cpuReq),
    .cpuGrant(cpuGrant),
    .loadReq(loadReq),
    .loadGrant(loadGrant),
    .loadAddr(loadAddr),
    .bvalid(bvalid),
    .bready(bready),
    .fetchValid(fetchValid),
    .tileValid(tileValid)
);

`default_nettype wire

//--- sim/nameTable_golden.hex
// kind 3/1 write: K AAA S 000 DDDDDDDD (3 during load, 1 after), addr, strobe, data
// kind 2 fetch: 2 0 XX YY 000000 II 0P, column, row, tile index, palette; kind 0 ends
3190F000DEADBEEF
33E030000F0F0F0F
10105000AABBCCDD
13C4800012345678
2000000000005A02
201000000000DD02
2011000000004B02
201200000000BB03
2013000000004903
2018000000004200
201A000000004003
2018020000000201
201A020000000002
201C000000004602
201E000000004400
201C020000000601
201E020000000400
201F1D000000E501
20050D000000FF03
200A160000009002
0000000000000000

//--- sim/tb_nameTable.sv
/* name table store testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_nameTable;

    // 1024 bytes at ~75% valid is ~1400 cycles, plus sweep and writes, lots of margin
    localparam int timeoutCycles = 20000;
    localparam int goldenDepth   = 64;

    logic                    clk_flashToNametable;
    logic                    rst;
    logic                    awvalid;
    logic                    awready;
    nameTablePkg::busAddrT   awaddr;
    logic                    wvalid;
    logic                    wready;
    nameTablePkg::wordT      wdata;
    nameTablePkg::byteEnT    wstrb;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    flashValid;
    logic                    flashReady;
    nameTablePkg::tileIdxT   flashByte;
    logic                    loadStart;
    logic                    loadDone;
    logic                    fetchValid;
    nameTablePkg::tileCoordT tileX;
    nameTablePkg::tileCoordT tileY;
    logic                    tileValid;
    nameTablePkg::tileIdxT   tileIndex;
    nameTablePkg::paletteT   paletteSel;

    logic [63:0]            golden [0:goldenDepth-1];
    // mirror of the ram, updated at every granted write
    nameTablePkg::wordT     modelMem [0:255];
    nameTablePkg::wordAddrT curAddr;
    nameTablePkg::wordT     curData;
    nameTablePkg::byteEnT   curStrb;
    nameTablePkg::tileIdxT  idxQ [$];
    nameTablePkg::paletteT  palQ [$];
    int                     coordQ [$];
    int errorCount;
    int fetchCount;
    int writeCount;
    int cycleCount;
    int sentBytes;
    int loadWords;
    int loadDoneCount;
    int stallCycles;
    int seed;
    int gi;
    int x;
    int y;

    nameTableTop dut (
        .clk_flashToNametable(clk_flashToNametable),
        .rst(rst),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .wdata(wdata),
        .wstrb(wstrb),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .flashValid(flashValid),
        .flashReady(flashReady),
        .flashByte(flashByte),
        .loadStart(loadStart),
        .loadDone(loadDone),
        .fetchValid(fetchValid),
        .tileX(tileX),
        .tileY(tileY),
        .tileValid(tileValid),
        .tileIndex(tileIndex),
        .paletteSel(paletteSel)
    );

    initial begin
        clk_flashToNametable = 1'b0;
        forever #10 clk_flashToNametable = ~clk_flashToNametable;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk_flashToNametable);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("Some tests failed");
        $finish;
    end

    // flash rule, byte k is k xor 5a, first byte in lane 0
    function automatic nameTablePkg::wordT flashWord(input int w);
        nameTablePkg::wordT v;
        for (int k = 0; k < 4; k++) begin
            v[8*k +: 8] = 8'(4*w + k) ^ 8'h5a;
        end
        return v;
    endfunction

    function automatic nameTablePkg::tileIdxT modelIndex(input int cx, input int cy);
        int k;
        k = cy*32 + cx;
        return modelMem[k/4][8*(k%4) +: 8];
    endfunction

    // quadrant rule on the attribute byte of the 4x4 block
    function automatic nameTablePkg::paletteT modelPalette(input int cx, input int cy);
        int         a;
        int         sh;
        logic [7:0] b;
        a  = (cy/4)*8 + cx/4;
        b  = modelMem[240 + a/4][8*(a%4) +: 8];
        sh = 4*((cy%4)/2) + 2*((cx%4)/2);
        return nameTablePkg::paletteT'(b >> sh);
    endfunction

    // mirror granted writes, count loader words and done pulses
    always @(posedge clk_flashToNametable) begin : modelUpdate
        int b;
        if (!rst) begin
            if (dut.cpuGrant) begin
                for (b = 0; b < 4; b++) begin
                    if (curStrb[b]) begin
                        modelMem[curAddr][8*b +: 8] = curData[8*b +: 8];
                    end
                end
            end
            if (dut.loadGrant) begin
                modelMem[loadWords[7:0]] = flashWord(loadWords);
                loadWords++;
            end
            // every processor request cycle holds back a waiting loader word
            if (dut.loadReq && dut.cpuReq) begin
                stallCycles++;
            end
            if (loadDone) begin
                loadDoneCount++;
            end
        end
    end

    // compare fetch results in issue order
    always @(posedge clk_flashToNametable) begin : fetchCheck
        nameTablePkg::tileIdxT eIdx;
        nameTablePkg::paletteT ePal;
        int                    c;
        if (tileValid) begin
            if (idxQ.size() == 0) begin
                errorCount++;
                $display("tileValid came with no fetch outstanding at %0t", $time);
            end else begin
                eIdx = idxQ.pop_front();
                ePal = palQ.pop_front();
                c    = coordQ.pop_front();
                assert (tileIndex == eIdx) else begin
                    errorCount++;
                    $display("Error at %0t: tileIndex got %h expected %h (x %0d y %0d)",
                             $time, tileIndex, eIdx, c % 32, c / 32);
                end
                assert (paletteSel == ePal) else begin
                    errorCount++;
                    $display("Error at %0t: paletteSel got %0d expected %0d (x %0d y %0d)",
                             $time, paletteSel, ePal, c % 32, c / 32);
                end
            end
        end
    end

    // random gaps on the stream, each accepted byte advances k
    task automatic streamFlash();
        logic taken;
        while (sentBytes < 1024) begin
            @(posedge clk_flashToNametable);
            taken = flashValid && flashReady;
            if (taken) begin
                sentBytes++;
            end
            #2;
            if (sentBytes >= 1024) begin
                flashValid = 1'b0;
            end else if (taken || !flashValid) begin
                // an offered byte stays on the bus until taken
                flashValid = ($random(seed) & 3) != 0;
                flashByte  = 8'(sentBytes) ^ 8'h5a;
            end
        end
    endtask

    task automatic cpuWrite(input nameTablePkg::busAddrT a, input nameTablePkg::wordT d,
                            input nameTablePkg::byteEnT s);
        logic awDone;
        logic wDone;
        logic respDone;
        curAddr = a[9:2];
        curData = d;
        curStrb = s;
        awDone  = 1'b0;
        wDone   = 1'b0;
        @(posedge clk_flashToNametable);
        #2;
        awvalid = 1'b1;
        awaddr  = a;
        wvalid  = 1'b1;
        wdata   = d;
        wstrb   = s;
        bready  = 1'b0;
        while (!(awDone && wDone)) begin
            @(posedge clk_flashToNametable);
            if (awvalid && awready) awDone = 1'b1;
            if (wvalid && wready) wDone = 1'b1;
            #2;
            if (awDone) awvalid = 1'b0;
            if (wDone) wvalid = 1'b0;
        end
        // response held one cycle with bready low
        while (!bvalid) begin
            @(posedge clk_flashToNametable);
        end
        assert (!awready && !wready) else begin
            errorCount++;
            $display("Error at %0t: awready %b wready %b expected 0 0 while response held",
                     $time, awready, wready);
        end
        #2;
        bready   = 1'b1;
        respDone = 1'b0;
        while (!respDone) begin
            @(posedge clk_flashToNametable);
            if (bvalid && bready) begin
                respDone = 1'b1;
                // OKAY for every 10-bit address
                assert (bresp == 2'b00) else begin
                    errorCount++;
                    $display("Error at %0t: bresp got %b expected 00", $time, bresp);
                end
            end
        end
        #2;
        bready = 1'b0;
        writeCount++;
    endtask

    task automatic issueFetch(input int cx, input int cy, input nameTablePkg::tileIdxT eIdx,
                              input nameTablePkg::paletteT ePal);
        @(posedge clk_flashToNametable);
        #2;
        fetchValid = 1'b1;
        tileX      = nameTablePkg::tileCoordT'(cx);
        tileY      = nameTablePkg::tileCoordT'(cy);
        idxQ.push_back(eIdx);
        palQ.push_back(ePal);
        coordQ.push_back(cy*32 + cx);
        fetchCount++;
    endtask

    task automatic drainFetches();
        @(posedge clk_flashToNametable);
        #2;
        fetchValid = 1'b0;
        while (idxQ.size() != 0) begin
            @(posedge clk_flashToNametable);
        end
    endtask

    initial begin
        seed          = 42;
        errorCount    = 0;
        fetchCount    = 0;
        writeCount    = 0;
        sentBytes     = 0;
        loadWords     = 0;
        loadDoneCount = 0;
        stallCycles   = 0;
        curAddr       = '0;
        curData       = '0;
        curStrb       = '0;
        rst           = 1'b1;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        bready        = 1'b0;
        flashValid    = 1'b0;
        flashByte     = '0;
        loadStart     = 1'b0;
        fetchValid    = 1'b0;
        tileX         = '0;
        tileY         = '0;
        $readmemh("sim/nameTable_golden.hex", golden);

        repeat (4) @(posedge clk_flashToNametable);
        #2;
        rst = 1'b0;
        @(posedge clk_flashToNametable);
        #2;
        loadStart = 1'b1;
        @(posedge clk_flashToNametable);
        #2;
        loadStart = 1'b0;

        // halfway through the load, one write lands behind the loader, one ahead
        fork
            streamFlash();
            begin
                while (loadWords < 128) @(posedge clk_flashToNametable);
                for (gi = 0; gi < goldenDepth && golden[gi][63:60] != 4'h0; gi++) begin
                    if (golden[gi][63:60] == 4'h3) begin
                        cpuWrite(golden[gi][57:48], golden[gi][31:0], golden[gi][47:44]);
                    end
                end
            end
        join
        while (loadDoneCount == 0) @(posedge clk_flashToNametable);
        repeat (3) @(posedge clk_flashToNametable);

        // table full, the stream stays closed
        assert (!flashReady) else begin
            errorCount++;
            $display("Error at %0t: flashReady got %b expected 0", $time, flashReady);
        end
        assert (loadWords == 256) else begin
            errorCount++;
            $display("Error at %0t: loadWords got %0d expected 256", $time, loadWords);
        end
        assert (loadDoneCount == 1) else begin
            errorCount++;
            $display("Error at %0t: loadDone pulses got %0d expected 1", $time, loadDoneCount);
        end
        assert (dut.u_writeArbiter.stallCount == 16'(stallCycles)) else begin
            errorCount++;
            $display("Error at %0t: stallCount got %0d expected %0d",
                     $time, dut.u_writeArbiter.stallCount, stallCycles);
        end

        // partial strobe writes after the load
        for (gi = 0; gi < goldenDepth && golden[gi][63:60] != 4'h0; gi++) begin
            if (golden[gi][63:60] == 4'h1) begin
                cpuWrite(golden[gi][57:48], golden[gi][31:0], golden[gi][47:44]);
            end
        end

        // golden fetches, back to back
        for (gi = 0; gi < goldenDepth && golden[gi][63:60] != 4'h0; gi++) begin
            if (golden[gi][63:60] == 4'h2) begin
                issueFetch(int'(golden[gi][52:48]), int'(golden[gi][44:40]),
                           golden[gi][15:8], golden[gi][1:0]);
            end
        end
        drainFetches();

        // whole screen against the mirror
        for (y = 0; y < 30; y++) begin
            for (x = 0; x < 32; x++) begin
                issueFetch(x, y, modelIndex(x, y), modelPalette(x, y));
            end
        end
        drainFetches();

        // bound protocol checks
        errorCount += dut.u_checker.failCount;

        $display("Summary: %0d errors, %0d fetches, %0d processor writes, %0d loader words",
                 errorCount, fetchCount, writeCount, loadWords);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/nameTablePkg.sv
logic/nameTableRam.sv
logic/cpuWriteSlave.sv
logic/flashLoader.sv
logic/writeArbiter.sv
logic/tileFetch.sv
logic/nameTableTop.sv
sim/nameTable_checker.sv
sim/tb_nameTable.sv
